// File: sources.f
rtl/bfpPkg.sv
rtl/prefixAnd.sv
rtl/leadSignDet.sv
rtl/signEncode.sv
rtl/blockBuffer.sv
rtl/blockCounter.sv
rtl/bfpControl.sv
rtl/normShifter.sv
rtl/bfpNormalizer.sv
bench/bfpNormalizerTb.sv

// File: bench/bfpNormalizerTb.sv
`timescale 1ns/1ps

module bfpNormalizerTb;

	import bfpPkg::*;

	localparam int lsdSpeed = 1;    // brent-kung prefix in the detector
	localparam int numBlocks = 6;
	localparam int numSamples = numBlocks * blockLen;
	localparam int resetCycles = 8;
	// four times the unstalled length of 8 in, 8 out and 2 turnaround cycles per block
	localparam int timeoutLimit = 4 * (numBlocks * (2 * blockLen + 2)) + resetCycles;

	logic clk;
	logic rstN;
	logic inValid;
	sample_t inSample;
	logic inReady;
	logic outValid;
	logic outReady;
	bfpBeat_t outBeat;

	integer seed;          // $random state
	int cycleCount = 0;
	int inPtr;             // samples accepted so far
	int outPtr;            // beats accepted so far
	logic inXfer;          // sample taken at the coming edge

	// stimulus table with one row per block
	logic [sampleWidth-1:0] samples [numSamples] = '{
		16'h0123, 16'hFF00, 16'h0040, 16'h0005, 16'hFFF0, 16'h0010, 16'h0400, 16'hFFFF,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF,
		16'h8000, 16'h0001, 16'h1234, 16'hFFFE, 16'h0000, 16'h7FFF, 16'hC000, 16'hFFFF,
		16'h0011, 16'h4000, 16'h0002, 16'hFFFC, 16'h2000, 16'h0100, 16'hFFF0, 16'hFFFF,
		16'h0003, 16'hFFFD, 16'h0001, 16'h0000, 16'hFFFF, 16'h0007, 16'hFFF8, 16'h0002
	};

	// minimum sign count of each row
	// row 0 limited by 0x0400, rows 3 and 4 by 0x8000 and 0x4000, row 5 by 0x0007
	logic [expWidth-1:0] blockExps [numBlocks] = '{
		4'd4, 4'd15, 4'd15, 4'd0, 4'd0, 4'd12
	};

	bfpNormalizer #(
		.speed(lsdSpeed)
	) UUT (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inSample(inSample),
		.inReady(inReady),
		.outValid(outValid),
		.outReady(outReady),
		.outBeat(outBeat)
	);

	always #4 clk = ~clk; // 8 ns period

	// run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("timeout after %0d cycles, only %0d of %0d beats came out",
				cycleCount, outPtr, numSamples);
			$display("Test failed");
			$fatal(1, "run did not finish in time");
		end
	end

	task automatic compareValues(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// channel state implied by the counters at the falling edge
	task automatic verifyHandshakes();
		logic blockPending; // full block not yet drained
		blockPending = (inPtr > outPtr) && ((inPtr % blockLen) == 0);
		compareValues($sformatf("inReady after %0d samples, %0d beats", inPtr, outPtr),
			!blockPending, inReady);
		if (!blockPending)
			compareValues($sformatf("outValid after %0d samples, %0d beats", inPtr, outPtr),
				0, outValid);
		else if ((outPtr % blockLen) != 0)
			compareValues($sformatf("outValid mid drain, beat %0d", outPtr), 1, outValid);
	endtask

	// beat on the bus against the table
	task automatic scoreBeat();
		logic [sampleWidth-1:0] expMant;
		logic [expWidth-1:0] expExp;
		int blk;
		blk = outPtr / blockLen;
		expExp = blockExps[blk];
		expMant = samples[outPtr] << expExp; // sign bits drop off the top
		compareValues($sformatf("beat %0d mantissa", outPtr), {16'd0, expMant},
			{16'd0, outBeat.mantissa});
		compareValues($sformatf("beat %0d exponent", outPtr), expExp, outBeat.exponent);
		compareValues($sformatf("beat %0d last", outPtr),
			(outPtr % blockLen) == (blockLen - 1), outBeat.last);
	endtask

	initial begin
		seed = 32'h3789;
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		inSample = '0;
		outReady = 1'b0;
		inPtr = 0;
		outPtr = 0;
		inXfer = 1'b0;

		repeat (resetCycles) @(negedge clk);
		// both channels closed while in reset
		compareValues("inReady in reset", 0, inReady);
		compareValues("outValid in reset", 0, outValid);
		rstN = 1'b1;

		while (outPtr < numSamples) begin
			@(negedge clk);
			verifyHandshakes();

			// hold a sample until taken and then maybe leave a gap
			if (!inValid || inXfer) begin
				if (inPtr < numSamples)
					inValid = (($random(seed) & 3) != 0);
				else
					inValid = 1'b0;
			end
			inSample = (inPtr < numSamples) ? samples[inPtr] : '0;
			outReady = (($random(seed) & 1) != 0); // heavy back-pressure

			// handshakes completing at the next rising edge
			inXfer = inValid & inReady;
			if (outValid && outReady) begin
				scoreBeat();
				outPtr++;
			end
			if (inXfer)
				inPtr++;
		end

		@(negedge clk);
		outReady = 1'b0;
		verifyHandshakes(); // back in fill with nothing pending

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: rtl/bfpNormalizer.sv
`timescale 1ns/1ps

module bfpNormalizer #(
	parameter int speed = 1 // prefix structure in the sign detector
) (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  bfpPkg::sample_t inSample,
	output logic inReady,
	output logic outValid,
	input  logic outReady,
	output bfpPkg::bfpBeat_t outBeat
);

	import bfpPkg::*;

	logic [sampleWidth-1:0] oneHot;
	logic [expWidth-1:0] signCount; // of the incoming sample
	logic [expWidth-1:0] blockExp;
	logic [idxWidth-1:0] idx;       // fill and drain share it
	logic atLast;
	logic wrEn;
	logic first;
	logic inc;
	logic load;
	logic drainDone;
	sample_t rdData;

	// final beat of the block leaves
	assign drainDone = outValid & outReady & outBeat.last;

	leadSignDet #(
		.speed(speed)
	) uLsd (
		.sample(inSample),
		.oneHot(oneHot)
	);

	signEncode uEnc (
		.oneHot(oneHot),
		.signCount(signCount)
	);

	blockBuffer uBuf (
		.clk(clk),
		.rstN(rstN),
		.wrEn(wrEn),
		.first(first),
		.wrIdx(idx),
		.wrData(inSample),
		.signCount(signCount),
		.rdIdx(idx),
		.rdData(rdData),
		.blockExp(blockExp)
	);

	blockCounter uCnt (
		.clk(clk),
		.rstN(rstN),
		.inc(inc),
		.idx(idx),
		.atLast(atLast)
	);

	bfpControl uCtrl (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.outReady(outReady),
		.atLast(atLast),
		.outValid(outValid),
		.idx(idx),
		.inReady(inReady),
		.wrEn(wrEn),
		.first(first),
		.inc(inc),
		.load(load)
	);

	normShifter uShift (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.sample(rdData),
		.blockExp(blockExp),
		.isLast(atLast),
		.drainDone(drainDone),
		.outValid(outValid),
		.outBeat(outBeat)
	);

endmodule

// File: rtl/normShifter.sv
`timescale 1ns/1ps

module normShifter (
	input  logic clk,
	input  logic rstN,
	input  logic load,                            // capture next beat
	input  bfpPkg::sample_t sample,               // from buffer read port
	input  logic [bfpPkg::expWidth-1:0] blockExp,
	input  logic isLast,                          // sample is slot 7
	input  logic drainDone,                       // last beat accepted
	output logic outValid,
	output bfpPkg::bfpBeat_t outBeat
);

	import bfpPkg::*;

	sample_t shifted;

	// redundant sign bits drop off the top as zeros shift in
	assign shifted = sample << blockExp;

	// beat payload held while stalled
	always_ff @(posedge clk) begin
		if (load) begin
			outBeat.mantissa <= shifted;
			outBeat.exponent <= blockExp;
			outBeat.last <= isLast;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			outValid <= 1'b0;
		else if (load)
			outValid <= 1'b1;
		else if (drainDone)
			outValid <= 1'b0; // block finished
	end

endmodule

// File: rtl/bfpControl.sv
`timescale 1ns/1ps

module bfpControl (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  logic outReady,
	input  logic atLast,                     // counter at slot 7
	input  logic outValid,                   // beat pending in shifter
	input  logic [bfpPkg::idxWidth-1:0] idx,
	output logic inReady,
	output logic wrEn,                       // store sample
	output logic first,                      // restart minimum
	output logic inc,                        // advance counter
	output logic load                        // register next beat
);

	typedef enum logic [1:0] {
		sIdle,  // one cycle after reset
		sFill,
		sDrain
	} ctrlState_t;

	ctrlState_t state;
	logic outXfer;   // beat accepted downstream
	logic lastBeat;  // pending beat closes the block

	assign inReady = (state == sFill);
	assign wrEn = inReady & inValid;
	assign first = inReady & (idx == '0);

	// after slot 7 is loaded the counter has wrapped to 0
	assign outXfer = outValid & outReady;
	assign lastBeat = outValid & (idx == '0);

	// load on drain entry, then on every transfer except the last
	assign load = (state == sDrain) & (~outValid | (outXfer & ~lastBeat));
	assign inc = wrEn | load;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= sIdle;
		end else begin
			case (state)
				sIdle: state <= sFill;
				sFill: begin
					if (wrEn && atLast)
						state <= sDrain; // block full, minimum final
				end
				sDrain: begin
					if (outXfer && lastBeat)
						state <= sFill;
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

// File: rtl/blockCounter.sv
`timescale 1ns/1ps

module blockCounter (
	input  logic clk,
	input  logic rstN,
	input  logic inc,                        // step to next sample
	output logic [bfpPkg::idxWidth-1:0] idx, // shared fill/drain index
	output logic atLast                      // idx is the final slot
);

	import bfpPkg::*;

	assign atLast = (idx == idxWidth'(blockLen - 1));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			idx <= '0;
		end else if (inc) begin
			if (atLast)
				idx <= '0; // wrap for the next phase
			else
				idx <= idx + 1'b1;
		end
	end

endmodule

// File: rtl/blockBuffer.sv
`timescale 1ns/1ps

module blockBuffer (
	input  logic clk,
	input  logic rstN,
	input  logic wrEn,                             // input transfer
	input  logic first,                            // write opens a new block
	input  logic [bfpPkg::idxWidth-1:0] wrIdx,
	input  bfpPkg::sample_t wrData,
	input  logic [bfpPkg::expWidth-1:0] signCount, // of wrData
	input  logic [bfpPkg::idxWidth-1:0] rdIdx,
	output bfpPkg::sample_t rdData,
	output logic [bfpPkg::expWidth-1:0] blockExp   // min sign count so far
);

	import bfpPkg::*;

	sample_t mem [blockLen]; // sample store
	logic [expWidth-1:0] minCount;

	always_ff @(posedge clk) begin
		if (wrEn)
			mem[wrIdx] <= wrData;
	end

	// running minimum, restarted by the first write of a block
	always_ff @(posedge clk) begin
		if (!rstN) begin
			minCount <= '1;
		end else if (wrEn) begin
			if (first || (signCount < minCount))
				minCount <= signCount;
		end
	end

	assign rdData = mem[rdIdx]; // async read for the shifter
	assign blockExp = minCount;

endmodule

// File: rtl/signEncode.sv
`timescale 1ns/1ps

module signEncode (
	input  logic [bfpPkg::sampleWidth-1:0] oneHot, // from leadSignDet
	output logic [bfpPkg::expWidth-1:0] signCount  // redundant sign bits
);

	import bfpPkg::*;

	logic [expWidth-1:0] pos; // binary position of the set bit
	logic anyDiff;            // low when sample is 0 or -1

	// each index bit is the or of every code bit whose position has it set
	always_comb begin
		pos = '0;
		for (int i = 0; i < sampleWidth; i++) begin
			for (int b = 0; b < expWidth; b++) begin
				if (i[b])
					pos[b] = pos[b] | oneHot[i];
			end
		end
	end

	assign anyDiff = |oneHot;

	// count = sampleWidth-2-pos, all sign bits gives 15
	assign signCount = anyDiff ? expWidth'(sampleWidth - 2) - pos : '1;

endmodule

// File: rtl/leadSignDet.sv
`timescale 1ns/1ps

module leadSignDet #(
	parameter int speed = 1 // prefix structure select
) (
	input  bfpPkg::sample_t sample,                    // operand
	output logic [bfpPkg::sampleWidth-1:0] oneHot      // first bit differing from sign
);

	import bfpPkg::*;

	localparam int w = sampleWidth;

	logic sign;
	logic [w-2:0] propIn;    // bit equals sign
	logic [w-2:0] propInRev; // msb side first
	logic [w-2:0] propOutRev;
	logic [w-2:0] propOut;   // all bits from msb-1 down to here equal sign

	assign sign = sample[w-1];

	for (genvar i = 0; i <= w - 2; i++) begin : prop
		assign propIn[i] = ~(sign ^ sample[i]);
		assign propInRev[i] = propIn[w-2-i]; // reverse so prefix runs from the top
		assign propOut[i] = propOutRev[w-2-i];
	end

	prefixAnd #(
		.width(w - 1),
		.speed(speed)
	) uPrefix (
		.PI(propInRev),
		.PO(propOutRev)
	);

	// msb never marked, bit below it needs no prefix
	assign oneHot[w-1] = 1'b0;
	assign oneHot[w-2] = sign ^ sample[w-2];
	for (genvar i = 0; i <= w - 3; i++) begin : code
		assign oneHot[i] = propOut[i+1] & (sign ^ sample[i]); // first mismatch only
	end

endmodule

// File: rtl/prefixAnd.sv
`timescale 1ns/1ps

module prefixAnd #(
	parameter int width = 8, // prefix problem width
	parameter int speed = 1  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] PI, // propagate in
	output logic [width-1:0] PO  // and of all bits at or below
);

	localparam int depth = $clog2(width); // tree depth

	if (speed == 2) begin : sklansky
		// one row per level, row 0 is the input
		logic [width-1:0] pt [0:depth];

		assign pt[0] = PI;
		for (genvar l = 1; l <= depth; l++) begin : levels
			for (genvar i = 0; i < width; i++) begin : bits
				// upper half of each 2**l group takes the top of the lower half
				if (((i >> (l - 1)) & 1) == 1) begin : black
					assign pt[l][i] = pt[l-1][i] & pt[l-1][((i >> (l - 1)) << (l - 1)) - 1];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		assign PO = pt[depth];
	end else if (speed == 1) begin : brentKung
		// up-sweep rows 1..depth, down-sweep rows depth+1..2*depth-1
		logic [width-1:0] pt [0:2*depth-1];

		assign pt[0] = PI;

		// up-sweep, combine at the top bit of each 2**l group
		for (genvar l = 1; l <= depth; l++) begin : upLevels
			for (genvar i = 0; i < width; i++) begin : bits
				if (((i + 1) % (2 ** l)) == 0) begin : black
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2 ** (l - 1)];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		// down-sweep, fill the middle of each group, span halves per level
		for (genvar l = depth + 1; l <= 2 * depth - 1; l++) begin : downLevels
			localparam int span = 2 ** (2 * depth - 1 - l);
			for (genvar i = 0; i < width; i++) begin : bits
				if ((((i + 1) % (2 * span)) == span) && (i >= 2 * span)) begin : black
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - span];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		assign PO = pt[2*depth-1];
	end else begin : serial
		logic [width-1:0] pt; // ripple chain

		assign pt[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign pt[i] = PI[i] & pt[i-1];
		end
		assign PO = pt;
	end

endmodule

// File: rtl/bfpPkg.sv
package bfpPkg;

	// sample format
	localparam int sampleWidth = 16;

	// samples per block, fixed, no partial blocks
	localparam int blockLen = 8;

	localparam int idxWidth = $clog2(blockLen); // buffer index, 3 bits

	// sign count / exponent, 0..15
	localparam int expWidth = 4;

	// signed fixed-point word
	typedef logic signed [sampleWidth-1:0] sample_t;

	// one output beat, 21 bits
	typedef struct packed {
		sample_t mantissa;              // normalized sample
		logic [expWidth-1:0] exponent;  // block exponent
		logic last;                     // eighth beat of the block
	} bfpBeat_t;

endpackage
